// File: src/lsu_pkg.sv
// ==============================
// Load/store unit shared package
//   Bus and lane widths
//   Word, byte-select and lane types
//   Access size encoding
//   Size to byte-mask helper
// ==============================

`default_nettype none

package lsu_pkg;

  localparam int DATA_W = 32;
  localparam int LANES  = DATA_W / 8;

  typedef logic [DATA_W-1:0]        data_t;
  typedef logic [LANES-1:0]         sel_t;
  typedef logic [$clog2(LANES)-1:0] lane_t;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // Byte mask of an access, anchored at lane 0
  function automatic sel_t size_mask(size_e size);
    sel_t mask;
    case (size)
      SIZE_BYTE: mask = 4'b0001;
      SIZE_HALF: mask = 4'b0011;
      default:   mask = 4'b1111;
    endcase
    return mask;
  endfunction

endpackage

`default_nettype wire

// File: src/lsu_info_buf.sv
// ==============================
// Request information buffer
//   Address generation
//   Latched request fields
//   Split detection, beat address
// ==============================

`timescale 1ns/1ps
`default_nettype none

module lsu_info_buf #(
  parameter int ADDR_W = 32
) (
  input  wire logic              forever_cpuclk,
  input  wire logic              arst_n,
  input  wire logic              accept,
  input  wire logic              second_beat,
  input  wire logic              store,
  input  lsu_pkg::size_e         size,
  input  wire logic              uns,
  input  wire logic [ADDR_W-1:0] base,
  input  wire logic [ADDR_W-1:0] offset,
  input  lsu_pkg::data_t         wdata,
  output logic                   buf_store,
  output lsu_pkg::size_e         buf_size,
  output logic                   buf_uns,
  output lsu_pkg::lane_t         buf_lane,
  output lsu_pkg::data_t         buf_wdata,
  output logic                   split,
  output logic [ADDR_W-3:0]      wb_adr
);

  import lsu_pkg::*;

  logic [ADDR_W-1:0]  addr_sum;
  logic [ADDR_W-3:0]  word_adr_q;
  logic [2*LANES-1:0] span;

  assign addr_sum = base + offset;

  // Access attributes steer the control path
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      buf_store <= 1'b0;
      buf_size  <= SIZE_BYTE;
      buf_uns   <= 1'b0;
      buf_lane  <= '0;
    end else if (accept) begin
      buf_store <= store;
      buf_size  <= size;
      buf_uns   <= uns;
      buf_lane  <= addr_sum[1:0];
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (accept) begin
      word_adr_q <= addr_sum[ADDR_W-1:2];
      buf_wdata  <= wdata;
    end
  end

  // Bytes past lane 3 spill into the next word
  assign span  = {{LANES{1'b0}}, size_mask(buf_size)} << buf_lane;
  assign split = |span[2*LANES-1:LANES];

  assign wb_adr = word_adr_q + {{(ADDR_W-3){1'b0}}, second_beat};

endmodule

`default_nettype wire

// File: src/lsu_ctrl.sv
// ==============================
// Load/store control
//   Beat sequencing FSM
//   Wishbone cycle control
//   Busy, done and error reporting
// ==============================

`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
  input  wire logic forever_cpuclk,
  input  wire logic arst_n,
  input  wire logic req,
  input  wire logic split,
  input  wire logic buf_store,
  input  wire logic wb_ack,
  input  wire logic wb_err,
  output logic      accept,
  output logic      second_beat,
  output logic      beat_ack,
  output logic      busy,
  output logic      done,
  output logic      err,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we
);

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_BEAT0 = 2'd1,
    ST_BEAT1 = 2'd2,
    ST_DONE  = 2'd3
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   in_beat;
  logic   beat_end;

  assign in_beat  = (state_q == ST_BEAT0) || (state_q == ST_BEAT1);
  assign beat_end = in_beat && (wb_ack || wb_err);

  assign accept = req && (state_q == ST_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_BEAT0;
        end
      end
      ST_BEAT0: begin
        // An error on the first beat cancels the second
        if (beat_end) begin
          if (split && !wb_err) begin
            state_d = ST_BEAT1;
          end else begin
            state_d = ST_DONE;
          end
        end
      end
      ST_BEAT1: begin
        if (beat_end) begin
          state_d = ST_DONE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Sticky over the access, cleared on the next accept
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      err <= 1'b0;
    end else if (accept) begin
      err <= 1'b0;
    end else if (in_beat && wb_err) begin
      err <= 1'b1;
    end
  end

  assign second_beat = (state_q == ST_BEAT1);
  assign beat_ack    = in_beat && wb_ack;

  assign busy = (state_q != ST_IDLE);
  assign done = (state_q == ST_DONE);

  // Held stable across wait states and between beats
  assign wb_cyc = in_beat;
  assign wb_stb = in_beat;
  assign wb_we  = in_beat && buf_store;

endmodule

`default_nettype wire

// File: src/lsu_align.sv
// ==============================
// Data alignment
//   Store lane rotation, byte selects
//   Load merge over one or two beats
//   Sign and zero extension
// ==============================

`timescale 1ns/1ps
`default_nettype none

module lsu_align (
  input  wire logic       forever_cpuclk,
  input  wire logic       arst_n,
  input  wire logic       beat_ack,
  input  wire logic       second_beat,
  input  lsu_pkg::size_e  buf_size,
  input  wire logic       buf_uns,
  input  lsu_pkg::lane_t  buf_lane,
  input  lsu_pkg::data_t  buf_wdata,
  input  lsu_pkg::data_t  wb_dat_r,
  output lsu_pkg::sel_t   wb_sel,
  output lsu_pkg::data_t  wb_dat_w,
  output lsu_pkg::data_t  rdata
);

  import lsu_pkg::*;

  logic [4:0]          shamt;
  logic [2*LANES-1:0]  span;
  logic [2*DATA_W-1:0] wdata_dbl;
  logic [2*DATA_W-1:0] rdata_dbl;
  logic [2*LANES-1:0]  sel_dbl;
  data_t               rdata_rot;
  sel_t                sel_rot;
  data_t               merge_q;

  assign shamt = {buf_lane, 3'b000};

  // Store side
  assign span = {{LANES{1'b0}}, size_mask(buf_size)} << buf_lane;

  assign wb_sel = second_beat ? span[2*LANES-1:LANES] : span[LANES-1:0];

  // Rotate left so byte 0 lands on the start lane
  assign wdata_dbl = {buf_wdata, buf_wdata} << shamt;
  assign wb_dat_w  = wdata_dbl[2*DATA_W-1:DATA_W];

  // Load side, bus lanes rotated back toward lane 0
  assign rdata_dbl = {wb_dat_r, wb_dat_r} >> shamt;
  assign rdata_rot = rdata_dbl[DATA_W-1:0];
  assign sel_dbl   = {wb_sel, wb_sel} >> buf_lane;
  assign sel_rot   = sel_dbl[LANES-1:0];

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      merge_q <= '0;
    end else if (beat_ack) begin
      for (int i = 0; i < LANES; i++) begin
        if (sel_rot[i]) begin
          merge_q[8*i +: 8] <= rdata_rot[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    case (buf_size)
      SIZE_BYTE: rdata = {{(DATA_W-8){~buf_uns & merge_q[7]}}, merge_q[7:0]};
      SIZE_HALF: rdata = {{(DATA_W-16){~buf_uns & merge_q[15]}}, merge_q[15:0]};
      default:   rdata = merge_q;
    endcase
  end

endmodule

`default_nettype wire

// File: src/lsu_top.sv
// ==============================
// Load/store unit top level
//   Core request port
//   Wishbone classic master port
//   Info buffer, control, alignment
// ==============================

`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int ADDR_W = 32
) (
  input  wire                logic forever_cpuclk,
  input  wire                logic arst_n,
  // Core side
  input  wire                logic req,
  input  wire                logic store,
  input  lsu_pkg::size_e     size,
  input  wire                logic uns,
  input  wire  logic [ADDR_W-1:0] base,
  input  wire  logic [ADDR_W-1:0] offset,
  input  lsu_pkg::data_t     wdata,
  output logic               busy,
  output logic               done,
  output logic               err,
  output lsu_pkg::data_t     rdata,
  // Wishbone side
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output logic [ADDR_W-3:0]  wb_adr,
  output lsu_pkg::sel_t      wb_sel,
  output lsu_pkg::data_t     wb_dat_w,
  input  wire                logic wb_ack,
  input  wire                logic wb_err,
  input  lsu_pkg::data_t     wb_dat_r
);

  import lsu_pkg::*;

  logic  accept;
  logic  second_beat;
  logic  beat_ack;
  logic  split;
  logic  buf_store;
  logic  buf_uns;
  size_e buf_size;
  lane_t buf_lane;
  data_t buf_wdata;

  lsu_info_buf #(
    .ADDR_W (ADDR_W)
  ) x_lsu_info_buf (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .accept         (accept),
    .second_beat    (second_beat),
    .store          (store),
    .size           (size),
    .uns            (uns),
    .base           (base),
    .offset         (offset),
    .wdata          (wdata),
    .buf_store      (buf_store),
    .buf_size       (buf_size),
    .buf_uns        (buf_uns),
    .buf_lane       (buf_lane),
    .buf_wdata      (buf_wdata),
    .split          (split),
    .wb_adr         (wb_adr)
  );

  lsu_ctrl x_lsu_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .req            (req),
    .split          (split),
    .buf_store      (buf_store),
    .wb_ack         (wb_ack),
    .wb_err         (wb_err),
    .accept         (accept),
    .second_beat    (second_beat),
    .beat_ack       (beat_ack),
    .busy           (busy),
    .done           (done),
    .err            (err),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we)
  );

  lsu_align x_lsu_align (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .beat_ack       (beat_ack),
    .second_beat    (second_beat),
    .buf_size       (buf_size),
    .buf_uns        (buf_uns),
    .buf_lane       (buf_lane),
    .buf_wdata      (buf_wdata),
    .wb_dat_r       (wb_dat_r),
    .wb_sel         (wb_sel),
    .wb_dat_w       (wb_dat_w),
    .rdata          (rdata)
  );

endmodule

`default_nettype wire

// File: tests/wb_mem_model.sv
// ==============================
// Wishbone classic slave memory
//   16 words, random wait states
//   Bus error past the last word
//   Beat counter, last byte select
// ==============================

`timescale 1ns/1ps
`default_nettype none

module wb_mem_model #(
  parameter int ADDR_W = 32,
  parameter int DEPTH  = 16
) (
  input  wire logic              forever_cpuclk,
  input  wire logic              arst_n,
  input  wire logic              wb_cyc,
  input  wire logic              wb_stb,
  input  wire logic              wb_we,
  input  wire logic [ADDR_W-3:0] wb_adr,
  input  lsu_pkg::sel_t          wb_sel,
  input  lsu_pkg::data_t         wb_dat_w,
  output logic                   wb_ack,
  output logic                   wb_err,
  output lsu_pkg::data_t         wb_dat_r,
  output logic [31:0]            beat_count,
  output lsu_pkg::sel_t          last_sel
);

  import lsu_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  data_t            mem [DEPTH];
  logic [1:0]       wait_cnt;
  logic [IDX_W-1:0] idx;
  logic             in_range;
  integer           seed = 32'h1478bf50;

  function automatic logic [1:0] draw_wait();
    integer r;
    r = $random(seed);
    return r[1:0];
  endfunction

  assign idx      = wb_adr[IDX_W-1:0];
  assign in_range = wb_adr < (ADDR_W-2)'(DEPTH);

  // Ack or err is a one-cycle pulse, a second beat starts counting after it
  always @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack     <= 1'b0;
      wb_err     <= 1'b0;
      wb_dat_r   <= '0;
      wait_cnt   <= 2'd0;
      beat_count <= 32'd0;
      last_sel   <= '0;
      // Distinct word for every address
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= data_t'(32'h9e3779b9 * (i + 1));
      end
    end else begin
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
      if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
        if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else begin
          wait_cnt   <= draw_wait();
          beat_count <= beat_count + 32'd1;
          if (!in_range) begin
            wb_err <= 1'b1;
          end else begin
            wb_ack   <= 1'b1;
            last_sel <= wb_sel;
            wb_dat_r <= mem[idx];
            for (int b = 0; b < LANES; b++) begin
              if (wb_we && wb_sel[b]) begin
                mem[idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
              end
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_lsu_top.sv
// ==============================
// Load/store unit testbench
//   Request table and apply loop
//   Compare tasks, watchdog
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

  import lsu_pkg::*;

  localparam int ADDR_W       = 32;
  localparam int RESET_CYCLES = 5;
  localparam int ENTRY_CYCLES = 20;
  localparam int DONE_LIMIT   = 16;

  typedef struct packed {
    logic              store;
    size_e             size;
    logic              uns;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] offset;
    data_t             wdata;
    data_t             rdata;
    logic              err;
    logic [1:0]        beats;
    sel_t              sel;
  } entry_t;

  logic              forever_cpuclk;
  logic              arst_n;
  logic              req;
  logic              store;
  size_e             size;
  logic              uns;
  logic [ADDR_W-1:0] base;
  logic [ADDR_W-1:0] offset;
  data_t             wdata;
  logic              busy;
  logic              done;
  logic              err;
  data_t             rdata;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-3:0] wb_adr;
  sel_t              wb_sel;
  data_t             wb_dat_w;
  logic              wb_ack;
  logic              wb_err;
  data_t             wb_dat_r;
  logic [31:0]       beat_count;
  sel_t              last_sel;

  entry_t entries[$];
  logic   table_ready;
  int     checks;
  int     errors;

  lsu_top #(.ADDR_W(ADDR_W)) i_dut (.*);

  wb_mem_model #(.ADDR_W(ADDR_W)) i_mem (.*);

  task automatic add_entry(input logic st, input size_e sz, input logic un,
                           input logic [ADDR_W-1:0] b, input logic [ADDR_W-1:0] o,
                           input data_t wd, input data_t rd, input logic er,
                           input logic [1:0] bt, input sel_t sl);
    entries.push_back({st, sz, un, b, o, wd, rd, er, bt, sl});
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input sel_t got, input sel_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%01h, expected 0x%01h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Stimulus fields, then expected rdata, err, beat count and last byte select
  task automatic fill_table();
    add_entry(1'b1, SIZE_WORD, 1'b0, 32'h10, 32'h04, 32'h12345678, 32'h0, 1'b0, 2'd1, 4'hf);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h14, 32'h00, 32'h0, 32'h12345678, 1'b0, 2'd1, 4'hf);
    add_entry(1'b1, SIZE_WORD, 1'b0, 32'h18, 32'h08, 32'h80f77f85, 32'h0, 1'b0, 2'd1, 4'hf);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h30, 32'hfffffff0, 32'h0, 32'h80f77f85, 1'b0,
              2'd1, 4'hf);
    add_entry(1'b0, SIZE_BYTE, 1'b0, 32'h20, 32'h00, 32'h0, 32'hffffff85, 1'b0, 2'd1, 4'h1);
    add_entry(1'b0, SIZE_BYTE, 1'b1, 32'h20, 32'h00, 32'h0, 32'h00000085, 1'b0, 2'd1, 4'h1);
    add_entry(1'b0, SIZE_BYTE, 1'b0, 32'h20, 32'h01, 32'h0, 32'h0000007f, 1'b0, 2'd1, 4'h2);
    add_entry(1'b0, SIZE_BYTE, 1'b0, 32'h20, 32'h02, 32'h0, 32'hfffffff7, 1'b0, 2'd1, 4'h4);
    add_entry(1'b0, SIZE_HALF, 1'b0, 32'h20, 32'h00, 32'h0, 32'h00007f85, 1'b0, 2'd1, 4'h3);
    add_entry(1'b0, SIZE_HALF, 1'b0, 32'h20, 32'h02, 32'h0, 32'hffff80f7, 1'b0, 2'd1, 4'hc);
    add_entry(1'b0, SIZE_HALF, 1'b1, 32'h20, 32'h02, 32'h0, 32'h000080f7, 1'b0, 2'd1, 4'hc);
    // Byte to lane 2 leaves the rest of the word
    add_entry(1'b1, SIZE_BYTE, 1'b0, 32'h10, 32'h06, 32'h000000ab, 32'h0, 1'b0, 2'd1, 4'h4);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h14, 32'h00, 32'h0, 32'h12ab5678, 1'b0, 2'd1, 4'hf);
    // Word boundary crossings
    add_entry(1'b1, SIZE_WORD, 1'b0, 32'h20, 32'h05, 32'hcafef00d, 32'h0, 1'b0, 2'd2, 4'h1);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h20, 32'h05, 32'h0, 32'hcafef00d, 1'b0, 2'd2, 4'h1);
    add_entry(1'b0, SIZE_HALF, 1'b0, 32'h20, 32'h07, 32'h0, 32'hffffcafe, 1'b0, 2'd2, 4'h1);
    add_entry(1'b1, SIZE_HALF, 1'b0, 32'h28, 32'h03, 32'h00001357, 32'h0, 1'b0, 2'd2, 4'h1);
    add_entry(1'b0, SIZE_HALF, 1'b1, 32'h28, 32'h03, 32'h0, 32'h00001357, 1'b0, 2'd2, 4'h1);
    // Past the end of memory
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h40, 32'h00, 32'h0, 32'h0, 1'b1, 2'd1, 4'hf);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h40, 32'h02, 32'h0, 32'h0, 1'b1, 2'd1, 4'hf);
    add_entry(1'b0, SIZE_HALF, 1'b1, 32'h3c, 32'h03, 32'h0, 32'h0, 1'b1, 2'd2, 4'hf);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h14, 32'h00, 32'h0, 32'h12ab5678, 1'b0, 2'd1, 4'hf);
  endtask

  initial begin
    forever_cpuclk = 1'b0;
    forever #5 forever_cpuclk = ~forever_cpuclk;
  end

  initial begin
    wait (table_ready === 1'b1);
    repeat (RESET_CYCLES + 2 + ENTRY_CYCLES * entries.size()) @(posedge forever_cpuclk);
    $display("Timeout: the table did not finish within its cycle budget");
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    entry_t      e;
    int unsigned beats_before;
    int          cycles;
    int          errors_before;
    arst_n      = 1'b1;
    req         = 1'b0;
    store       = 1'b0;
    size        = SIZE_WORD;
    uns         = 1'b0;
    base        = '0;
    offset      = '0;
    wdata       = '0;
    checks      = 0;
    errors      = 0;
    fill_table();
    table_ready = 1'b1;
    @(negedge forever_cpuclk);
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge forever_cpuclk);
    arst_n = 1'b1;
    @(negedge forever_cpuclk);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    check_flag("wb_stb", wb_stb, 1'b0);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    $display("reset: %s", (errors == 0) ? "ok" : "mismatch");
    for (int i = 0; i < entries.size(); i++) begin
      e             = entries[i];
      errors_before = errors;
      beats_before  = beat_count;
      @(negedge forever_cpuclk);
      req    = 1'b1;
      store  = e.store;
      size   = e.size;
      uns    = e.uns;
      base   = e.base;
      offset = e.offset;
      wdata  = e.wdata;
      @(negedge forever_cpuclk);
      req    = 1'b0;
      cycles = 0;
      while (!done && cycles < DONE_LIMIT) begin
        @(negedge forever_cpuclk);
        cycles++;
      end
      if (!done) begin
        errors++;
        $display("entry %0d never signalled done within %0d cycles", i, DONE_LIMIT);
      end else begin
        // Busy holds through the done cycle
        check_flag("busy", busy, 1'b1);
        check_flag("err", err, e.err);
        check_data("beats", data_t'(beat_count - beats_before), data_t'(e.beats));
        if (!e.store && !e.err) begin
          check_data("rdata", rdata, e.rdata);
        end
        if (!e.err) begin
          check_sel("wb_sel", last_sel, e.sel);
        end
      end
      $display("entry %0d %s %s at 0x%08h: %s", i, e.store ? "store" : "load",
               e.size.name(), e.base + e.offset, (errors == errors_before) ? "ok" : "mismatch");
    end
    $display("%0d entries, %0d checks, %0d errors", entries.size(), checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: lsu_top.f
src/lsu_pkg.sv
src/lsu_info_buf.sv
src/lsu_ctrl.sv
src/lsu_align.sv
src/lsu_top.sv
tests/wb_mem_model.sv
tests/tb_lsu_top.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_lsu_top -f lsu_top.f -o sim_lsu_top; then
  echo "Verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/sim_lsu_top); then
  printf '%s\n' "$out"
  echo "Simulation exited with an error status"
  exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
